// File: rtl/dsi_regs_pkg.sv
`default_nettype none

package dsi_regs_pkg;

    // Bus word and address widths
    localparam int WORD_W     = 32;
    localparam int AVL_ADDR_W = 6;
    localparam int REG_IDX_W  = 4;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [AVL_ADDR_W-1:0] avl_addr_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;

    // Register map, index is byte offset / 4
    localparam reg_idx_t IDX_CR  = 4'd0;
    localparam reg_idx_t IDX_ISR = 4'd1;
    localparam reg_idx_t IDX_IER = 4'd2;
    localparam reg_idx_t IDX_TR1 = 4'd3;
    localparam reg_idx_t IDX_TR2 = 4'd4;
    localparam reg_idx_t IDX_CMD = 4'd5;
    localparam int       NUM_REGS = 6;

    // Field types
    localparam int TIMEOUT_W     = 8;
    localparam int CMD_W         = 24;
    localparam int LANES_FIELD_W = 2;
    localparam int IRQ_NUM       = 5;

    typedef logic [TIMEOUT_W-1:0]     timeout_t;
    typedef logic [CMD_W-1:0]         cmd_t;
    typedef logic [2:0]               lanes_num_t;
    typedef logic [LANES_FIELD_W-1:0] lanes_field_t;
    typedef logic [IRQ_NUM-1:0]       irq_vec_t;

    // Interrupt sources, same order in ISR and IER
    localparam int IRQ_UNDERFLOW   = 0;
    localparam int IRQ_LANES_READY = 1;
    localparam int IRQ_CLK_READY   = 2;
    localparam int IRQ_LANES_UP    = 3;
    localparam int IRQ_LANES_DOWN  = 4;

    // CR fields
    localparam int CR_ASM_EN_BIT   = 0;
    localparam int CR_LANES_EN_BIT = 1;
    localparam int CR_CLK_EN_BIT   = 2;
    localparam int CR_SEND_CMD_BIT = 3;
    localparam int CR_LANES_LSB    = 8;

    // TR1, TR2 and CMD fields
    localparam int TR1_TLPX_LSB  = 16;
    localparam int TR1_PREP_LSB  = 8;
    localparam int TR1_EXIT_LSB  = 0;
    localparam int TR2_GO_LSB    = 8;
    localparam int TR2_TRAIL_LSB = 0;
    localparam int CMD_LSB       = 0;

    // Reset values, lanes field holds count minus one
    localparam lanes_field_t RST_LANES_FIELD = 2'd3;
    localparam timeout_t     RST_TLPX        = 8'd8;
    localparam timeout_t     RST_PREP        = 8'd1;
    localparam timeout_t     RST_EXIT        = 8'd3;
    localparam timeout_t     RST_GO          = 8'd30;
    localparam timeout_t     RST_TRAIL       = 8'd2;

    // Avalon response codes
    typedef logic [1:0] avl_resp_t;
    localparam avl_resp_t AVL_RESP_OKAY      = 2'd0;
    localparam avl_resp_t AVL_RESP_DECODEERR = 2'd3;

endpackage

`default_nettype wire

// File: rtl/reg_bank_if.sv
`timescale 1ns/100ps
`default_nettype none

// Link from the bus agent to one register bank
interface reg_bank_if;
    import dsi_regs_pkg::*;

    // One-cycle strobe, only for mapped indexes
    logic     wr_stb;
    // Held for the whole access
    reg_idx_t idx;
    word_t    wdata;
    // Combinational from idx, zero for foreign indexes
    word_t    rdata;

    modport agent (
        output wr_stb,
        output idx,
        output wdata,
        input  rdata
    );

    modport bank (
        input  wr_stb,
        input  idx,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: rtl/avl_reg_agent.sv
`timescale 1ns/100ps
`default_nettype none

module avl_reg_agent (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire dsi_regs_pkg::avl_addr_t i_avl_addr,
    input  wire                        i_avl_read,
    input  wire                        i_avl_write,
    input  wire dsi_regs_pkg::word_t   i_avl_writedata,
    output dsi_regs_pkg::word_t        o_avl_readdata,
    output dsi_regs_pkg::avl_resp_t    o_avl_response,
    output logic                       o_avl_waitrequest,
    reg_bank_if.agent                  bank_ctrl,
    reg_bank_if.agent                  bank_irq
);
    import dsi_regs_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_DONE
    } state_t;

    state_t    state;
    logic      req;
    reg_idx_t  in_idx;
    logic      in_mapped;
    reg_idx_t  req_idx;
    word_t     req_wdata;
    logic      req_mapped;
    logic      wr_stb;
    word_t     merged_rdata;
    word_t     rdata_q;
    avl_resp_t resp_q;

    assign req       = i_avl_read || i_avl_write;
    assign in_idx    = i_avl_addr[AVL_ADDR_W-1:2];
    assign in_mapped = (in_idx < NUM_REGS);

    // Transfer sequencer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            wr_stb <= 1'b0;
        end else begin
            wr_stb <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state  <= ST_ACCESS;
                        wr_stb <= i_avl_write && in_mapped;
                    end
                end
                ST_ACCESS: state <= ST_DONE;
                ST_DONE:   state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // Request capture and read result
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            req_idx   <= in_idx;
            req_wdata <= i_avl_writedata;
        end
        if (state == ST_ACCESS) begin
            rdata_q <= req_mapped ? merged_rdata : '0;
            resp_q  <= req_mapped ? AVL_RESP_OKAY : AVL_RESP_DECODEERR;
        end
    end

    assign req_mapped   = (req_idx < NUM_REGS);
    assign merged_rdata = bank_ctrl.rdata | bank_irq.rdata;

    // Same write path to both banks
    assign bank_ctrl.wr_stb = wr_stb;
    assign bank_ctrl.idx    = req_idx;
    assign bank_ctrl.wdata  = req_wdata;
    assign bank_irq.wr_stb  = wr_stb;
    assign bank_irq.idx     = req_idx;
    assign bank_irq.wdata   = req_wdata;

    // Stall from the first request cycle until DONE
    assign o_avl_waitrequest = (state == ST_ACCESS) || (state == ST_IDLE && req);
    assign o_avl_readdata    = rdata_q;
    assign o_avl_response    = resp_q;

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_avl_read && i_avl_write))
        else $error("Avalon read and write raised together");

    a_wr_stb_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wr_stb |=> !wr_stb)
        else $error("Bank write strobe longer than one cycle");

endmodule

`default_nettype wire

// File: rtl/ctrl_reg_bank.sv
`timescale 1ns/100ps
`default_nettype none

module ctrl_reg_bank (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       i_lanes_active,
    reg_bank_if.bank                  bus,
    output logic                      o_assembler_en,
    output logic                      o_lanes_en,
    output logic                      o_clk_out_en,
    output logic                      o_send_cmd,
    output dsi_regs_pkg::lanes_num_t  o_lanes_number,
    output dsi_regs_pkg::cmd_t        o_cmd_packet,
    output dsi_regs_pkg::timeout_t    o_tlpx_timeout,
    output dsi_regs_pkg::timeout_t    o_hs_prepare_timeout,
    output dsi_regs_pkg::timeout_t    o_hs_exit_timeout,
    output dsi_regs_pkg::timeout_t    o_hs_go_timeout,
    output dsi_regs_pkg::timeout_t    o_hs_trail_timeout
);
    import dsi_regs_pkg::*;

    logic         wr_cr;
    logic         wr_tr1;
    logic         wr_tr2;
    logic         wr_cmd;
    logic         asm_en;
    logic         lanes_en;
    logic         clk_en;
    logic         send_cmd;
    lanes_field_t lanes_field;
    timeout_t     tlpx;
    timeout_t     hs_prep;
    timeout_t     hs_exit;
    timeout_t     hs_go;
    timeout_t     hs_trail;
    cmd_t         cmd;
    word_t        cr_word;
    word_t        tr1_word;
    word_t        tr2_word;
    word_t        cmd_word;

    assign wr_cr  = bus.wr_stb && (bus.idx == IDX_CR);
    assign wr_tr1 = bus.wr_stb && (bus.idx == IDX_TR1);
    assign wr_tr2 = bus.wr_stb && (bus.idx == IDX_TR2);
    assign wr_cmd = bus.wr_stb && (bus.idx == IDX_CMD);

    // CR enables and lane count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            asm_en      <= 1'b0;
            lanes_en    <= 1'b0;
            clk_en      <= 1'b0;
            lanes_field <= RST_LANES_FIELD;
        end else if (wr_cr) begin
            asm_en      <= bus.wdata[CR_ASM_EN_BIT];
            lanes_en    <= bus.wdata[CR_LANES_EN_BIT];
            clk_en      <= bus.wdata[CR_CLK_EN_BIT];
            lanes_field <= bus.wdata[CR_LANES_LSB +: LANES_FIELD_W];
        end
    end

    // Send-command drops once the lanes are up, a CR write wins
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            send_cmd <= 1'b0;
        end else if (wr_cr) begin
            send_cmd <= bus.wdata[CR_SEND_CMD_BIT];
        end else if (i_lanes_active) begin
            send_cmd <= 1'b0;
        end
    end

    // D-PHY timeouts
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tlpx     <= RST_TLPX;
            hs_prep  <= RST_PREP;
            hs_exit  <= RST_EXIT;
            hs_go    <= RST_GO;
            hs_trail <= RST_TRAIL;
        end else begin
            if (wr_tr1) begin
                tlpx    <= bus.wdata[TR1_TLPX_LSB +: TIMEOUT_W];
                hs_prep <= bus.wdata[TR1_PREP_LSB +: TIMEOUT_W];
                hs_exit <= bus.wdata[TR1_EXIT_LSB +: TIMEOUT_W];
            end
            if (wr_tr2) begin
                hs_go    <= bus.wdata[TR2_GO_LSB +: TIMEOUT_W];
                hs_trail <= bus.wdata[TR2_TRAIL_LSB +: TIMEOUT_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd <= '0;
        end else if (wr_cmd) begin
            cmd <= bus.wdata[CMD_LSB +: CMD_W];
        end
    end

    // Read words, reserved bits stay zero
    always_comb begin
        cr_word                                 = '0;
        cr_word[CR_ASM_EN_BIT]                  = asm_en;
        cr_word[CR_LANES_EN_BIT]                = lanes_en;
        cr_word[CR_CLK_EN_BIT]                  = clk_en;
        cr_word[CR_SEND_CMD_BIT]                = send_cmd;
        cr_word[CR_LANES_LSB +: LANES_FIELD_W]  = lanes_field;
        tr1_word                                = '0;
        tr1_word[TR1_TLPX_LSB +: TIMEOUT_W]     = tlpx;
        tr1_word[TR1_PREP_LSB +: TIMEOUT_W]     = hs_prep;
        tr1_word[TR1_EXIT_LSB +: TIMEOUT_W]     = hs_exit;
        tr2_word                                = '0;
        tr2_word[TR2_GO_LSB +: TIMEOUT_W]       = hs_go;
        tr2_word[TR2_TRAIL_LSB +: TIMEOUT_W]    = hs_trail;
        cmd_word                                = '0;
        cmd_word[CMD_LSB +: CMD_W]              = cmd;
    end

    always_comb begin
        case (bus.idx)
            IDX_CR:  bus.rdata = cr_word;
            IDX_TR1: bus.rdata = tr1_word;
            IDX_TR2: bus.rdata = tr2_word;
            IDX_CMD: bus.rdata = cmd_word;
            default: bus.rdata = '0;
        endcase
    end

    assign o_assembler_en       = asm_en;
    assign o_lanes_en           = lanes_en;
    assign o_clk_out_en         = clk_en;
    assign o_send_cmd           = send_cmd;
    assign o_lanes_number       = lanes_num_t'(lanes_field) + lanes_num_t'(1);
    assign o_cmd_packet         = cmd;
    assign o_tlpx_timeout       = tlpx;
    assign o_hs_prepare_timeout = hs_prep;
    assign o_hs_exit_timeout    = hs_exit;
    assign o_hs_go_timeout      = hs_go;
    assign o_hs_trail_timeout   = hs_trail;

    a_send_cmd_clr: assert property (@(posedge clk) disable iff (!rst_n)
        i_lanes_active && !wr_cr |=> !o_send_cmd)
        else $error("Send-command still set after the lanes came up");

endmodule

`default_nettype wire

// File: rtl/irq_reg_bank.sv
`timescale 1ns/100ps
`default_nettype none

module irq_reg_bank (
    input  wire      clk,
    input  wire      rst_n,
    input  wire      i_pix_buffer_underflow_set,
    input  wire      i_lanes_ready_set,
    input  wire      i_clk_ready_set,
    input  wire      i_lanes_active,
    reg_bank_if.bank bus,
    output logic     o_irq
);
    import dsi_regs_pkg::*;

    logic     wr_isr;
    logic     wr_ier;
    logic     la_q;
    logic     la_prev;
    logic     lanes_up;
    logic     lanes_down;
    irq_vec_t set_vec;
    irq_vec_t clr_vec;
    irq_vec_t isr;
    irq_vec_t ier;
    logic     irq_q;

    assign wr_isr = bus.wr_stb && (bus.idx == IDX_ISR);
    assign wr_ier = bus.wr_stb && (bus.idx == IDX_IER);

    // Lanes-active sampled, then compared with its previous value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            la_q    <= 1'b0;
            la_prev <= 1'b0;
        end else begin
            la_q    <= i_lanes_active;
            la_prev <= la_q;
        end
    end

    assign lanes_up   = la_q && !la_prev;
    assign lanes_down = !la_q && la_prev;

    always_comb begin
        set_vec                  = '0;
        set_vec[IRQ_UNDERFLOW]   = i_pix_buffer_underflow_set;
        set_vec[IRQ_LANES_READY] = i_lanes_ready_set;
        set_vec[IRQ_CLK_READY]   = i_clk_ready_set;
        set_vec[IRQ_LANES_UP]    = lanes_up;
        set_vec[IRQ_LANES_DOWN]  = lanes_down;
    end

    assign clr_vec = wr_isr ? bus.wdata[IRQ_NUM-1:0] : '0;

    // W1C beats a set in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            isr <= '0;
        end else begin
            isr <= (isr | set_vec) & ~clr_vec;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ier <= '0;
        end else if (wr_ier) begin
            ier <= bus.wdata[IRQ_NUM-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= |(isr & ier);
        end
    end

    always_comb begin
        case (bus.idx)
            IDX_ISR: bus.rdata = word_t'(isr);
            IDX_IER: bus.rdata = word_t'(ier);
            default: bus.rdata = '0;
        endcase
    end

    assign o_irq = irq_q;

    a_w1c_wins: assert property (@(posedge clk) disable iff (!rst_n)
        wr_isr |=> (isr & $past(clr_vec)) == '0)
        else $error("ISR bit survived a write-one clear");

endmodule

`default_nettype wire

// File: rtl/dsi_tx_regs.sv
`timescale 1ns/100ps
`default_nettype none

module dsi_tx_regs (
    input  wire                          clk,
    input  wire                          rst_n,
    // Avalon-MM slave
    input  wire dsi_regs_pkg::avl_addr_t i_avl_addr,
    input  wire                          i_avl_read,
    input  wire                          i_avl_write,
    input  wire dsi_regs_pkg::word_t     i_avl_writedata,
    output dsi_regs_pkg::word_t          o_avl_readdata,
    output dsi_regs_pkg::avl_resp_t      o_avl_response,
    output logic                         o_avl_waitrequest,
    // Transmitter events
    input  wire                          i_pix_buffer_underflow_set,
    input  wire                          i_lanes_ready_set,
    input  wire                          i_clk_ready_set,
    input  wire                          i_lanes_active,
    output logic                         o_irq,
    // Control fields
    output logic                         o_assembler_en,
    output logic                         o_lanes_en,
    output logic                         o_clk_out_en,
    output logic                         o_send_cmd,
    output dsi_regs_pkg::lanes_num_t     o_lanes_number,
    output dsi_regs_pkg::cmd_t           o_cmd_packet,
    output dsi_regs_pkg::timeout_t       o_tlpx_timeout,
    output dsi_regs_pkg::timeout_t       o_hs_prepare_timeout,
    output dsi_regs_pkg::timeout_t       o_hs_exit_timeout,
    output dsi_regs_pkg::timeout_t       o_hs_go_timeout,
    output dsi_regs_pkg::timeout_t       o_hs_trail_timeout
);

    reg_bank_if bank_ctrl ();
    reg_bank_if bank_irq ();

    avl_reg_agent u_agent (
        .clk               (clk),
        .rst_n             (rst_n),
        .i_avl_addr        (i_avl_addr),
        .i_avl_read        (i_avl_read),
        .i_avl_write       (i_avl_write),
        .i_avl_writedata   (i_avl_writedata),
        .o_avl_readdata    (o_avl_readdata),
        .o_avl_response    (o_avl_response),
        .o_avl_waitrequest (o_avl_waitrequest),
        .bank_ctrl         (bank_ctrl.agent),
        .bank_irq          (bank_irq.agent)
    );

    ctrl_reg_bank u_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_lanes_active       (i_lanes_active),
        .bus                  (bank_ctrl.bank),
        .o_assembler_en       (o_assembler_en),
        .o_lanes_en           (o_lanes_en),
        .o_clk_out_en         (o_clk_out_en),
        .o_send_cmd           (o_send_cmd),
        .o_lanes_number       (o_lanes_number),
        .o_cmd_packet         (o_cmd_packet),
        .o_tlpx_timeout       (o_tlpx_timeout),
        .o_hs_prepare_timeout (o_hs_prepare_timeout),
        .o_hs_exit_timeout    (o_hs_exit_timeout),
        .o_hs_go_timeout      (o_hs_go_timeout),
        .o_hs_trail_timeout   (o_hs_trail_timeout)
    );

    irq_reg_bank u_irq (
        .clk                        (clk),
        .rst_n                      (rst_n),
        .i_pix_buffer_underflow_set (i_pix_buffer_underflow_set),
        .i_lanes_ready_set          (i_lanes_ready_set),
        .i_clk_ready_set            (i_clk_ready_set),
        .i_lanes_active             (i_lanes_active),
        .bus                        (bank_irq.bank),
        .o_irq                      (o_irq)
    );

endmodule

`default_nettype wire

// File: sim/tb_dsi_tx_regs.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dsi_tx_regs;
    import dsi_regs_pkg::*;

    localparam int CLK_PERIOD      = 100;
    // Reads and writes issued by the sequence below
    localparam int PLANNED_XFERS   = 96;
    localparam int WATCHDOG_CYCLES = PLANNED_XFERS * 10 + 200;
    // Waitrequest high cycles per transfer
    localparam int STALL_CYCLES    = 2;

    logic       clk;
    logic       rst_n;
    avl_addr_t  avl_addr;
    logic       avl_read;
    logic       avl_write;
    word_t      avl_writedata;
    word_t      avl_readdata;
    avl_resp_t  avl_response;
    logic       avl_waitrequest;
    logic       underflow_set;
    logic       lanes_ready_set;
    logic       clk_ready_set;
    logic       lanes_active;
    logic       irq;
    logic       assembler_en;
    logic       lanes_en;
    logic       clk_out_en;
    logic       send_cmd;
    lanes_num_t lanes_number;
    cmd_t       cmd_packet;
    timeout_t   tlpx_timeout;
    timeout_t   hs_prepare_timeout;
    timeout_t   hs_exit_timeout;
    timeout_t   hs_go_timeout;
    timeout_t   hs_trail_timeout;

    // Shadow registers, kept as written
    word_t      sh_cr;
    word_t      sh_tr1;
    word_t      sh_tr2;
    word_t      sh_cmd;
    irq_vec_t   sh_isr;
    irq_vec_t   sh_ier;

    // Last completed transfer
    logic       last_write;
    reg_idx_t   last_idx;
    word_t      last_rdata;
    avl_resp_t  last_resp;
    int         last_stall;
    event       xfer_done;

    int         errors = 0;
    int         checks = 0;

    dsi_tx_regs dut0 (
        .clk                        (clk),
        .rst_n                      (rst_n),
        .i_avl_addr                 (avl_addr),
        .i_avl_read                 (avl_read),
        .i_avl_write                (avl_write),
        .i_avl_writedata            (avl_writedata),
        .o_avl_readdata             (avl_readdata),
        .o_avl_response             (avl_response),
        .o_avl_waitrequest          (avl_waitrequest),
        .i_pix_buffer_underflow_set (underflow_set),
        .i_lanes_ready_set          (lanes_ready_set),
        .i_clk_ready_set            (clk_ready_set),
        .i_lanes_active             (lanes_active),
        .o_irq                      (irq),
        .o_assembler_en             (assembler_en),
        .o_lanes_en                 (lanes_en),
        .o_clk_out_en               (clk_out_en),
        .o_send_cmd                 (send_cmd),
        .o_lanes_number             (lanes_number),
        .o_cmd_packet               (cmd_packet),
        .o_tlpx_timeout             (tlpx_timeout),
        .o_hs_prepare_timeout       (hs_prepare_timeout),
        .o_hs_exit_timeout          (hs_exit_timeout),
        .o_hs_go_timeout            (hs_go_timeout),
        .o_hs_trail_timeout         (hs_trail_timeout)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Read word of a register, reserved bits masked off
    function automatic word_t expected_read(input reg_idx_t idx);
        word_t m;
        m = '0;
        case (idx)
            IDX_CR: begin
                m[CR_ASM_EN_BIT]                 = 1'b1;
                m[CR_LANES_EN_BIT]               = 1'b1;
                m[CR_CLK_EN_BIT]                 = 1'b1;
                m[CR_SEND_CMD_BIT]               = 1'b1;
                m[CR_LANES_LSB +: LANES_FIELD_W] = '1;
                return sh_cr & m;
            end
            IDX_ISR: return word_t'(sh_isr);
            IDX_IER: return word_t'(sh_ier);
            IDX_TR1: begin
                m[TR1_TLPX_LSB +: TIMEOUT_W] = '1;
                m[TR1_PREP_LSB +: TIMEOUT_W] = '1;
                m[TR1_EXIT_LSB +: TIMEOUT_W] = '1;
                return sh_tr1 & m;
            end
            IDX_TR2: begin
                m[TR2_GO_LSB +: TIMEOUT_W]    = '1;
                m[TR2_TRAIL_LSB +: TIMEOUT_W] = '1;
                return sh_tr2 & m;
            end
            IDX_CMD: begin
                m[CMD_LSB +: CMD_W] = '1;
                return sh_cmd & m;
            end
            default: return '0;
        endcase
    endfunction

    task automatic model_reset();
        sh_cr                                = '0;
        sh_cr[CR_LANES_LSB +: LANES_FIELD_W] = RST_LANES_FIELD;
        sh_tr1                               = '0;
        sh_tr1[TR1_TLPX_LSB +: TIMEOUT_W]    = RST_TLPX;
        sh_tr1[TR1_PREP_LSB +: TIMEOUT_W]    = RST_PREP;
        sh_tr1[TR1_EXIT_LSB +: TIMEOUT_W]    = RST_EXIT;
        sh_tr2                               = '0;
        sh_tr2[TR2_GO_LSB +: TIMEOUT_W]      = RST_GO;
        sh_tr2[TR2_TRAIL_LSB +: TIMEOUT_W]   = RST_TRAIL;
        sh_cmd                               = '0;
        sh_isr                               = '0;
        sh_ier                               = '0;
    endtask

    task automatic update_model(input reg_idx_t idx, input word_t data);
        case (idx)
            IDX_CR:  sh_cr = data;
            // Write one to clear
            IDX_ISR: sh_isr = sh_isr & ~data[IRQ_NUM-1:0];
            IDX_IER: sh_ier = data[IRQ_NUM-1:0];
            IDX_TR1: sh_tr1 = data;
            IDX_TR2: sh_tr2 = data;
            IDX_CMD: sh_cmd = data;
            default: ;
        endcase
    endtask

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        $display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    // Request held until waitrequest is seen low
    task automatic run_transfer(input logic is_write, input reg_idx_t idx, input word_t data);
        int stall;
        avl_addr      = {idx, 2'b00};
        avl_writedata = data;
        avl_write     = is_write;
        avl_read      = !is_write;
        stall         = 0;
        @(negedge clk);
        while (avl_waitrequest) begin
            stall++;
            @(negedge clk);
        end
        last_write = is_write;
        last_idx   = idx;
        last_rdata = avl_readdata;
        last_resp  = avl_response;
        last_stall = stall;
        -> xfer_done;
        @(posedge clk);
        #10;
        avl_read  = 1'b0;
        avl_write = 1'b0;
    endtask

    task automatic bus_write(input reg_idx_t idx, input word_t data);
        update_model(idx, data);
        run_transfer(1'b1, idx, data);
    endtask

    task automatic bus_read(input reg_idx_t idx);
        run_transfer(1'b0, idx, '0);
    endtask

    task automatic pulse_event(input int src);
        case (src)
            IRQ_UNDERFLOW:   underflow_set = 1'b1;
            IRQ_LANES_READY: lanes_ready_set = 1'b1;
            default:         clk_ready_set = 1'b1;
        endcase
        sh_isr[src] = 1'b1;
        @(posedge clk);
        #10;
        underflow_set   = 1'b0;
        lanes_ready_set = 1'b0;
        clk_ready_set   = 1'b0;
    endtask

    task automatic set_lanes_active(input logic val);
        if (val && !lanes_active) begin
            sh_isr[IRQ_LANES_UP]   = 1'b1;
            sh_cr[CR_SEND_CMD_BIT] = 1'b0;
        end
        if (!val && lanes_active) begin
            sh_isr[IRQ_LANES_DOWN] = 1'b1;
        end
        lanes_active = val;
        // Edge reaches ISR two clocks later
        idle(3);
    endtask

    task automatic check_irq();
        checks++;
        if (irq !== |(sh_isr & sh_ier))
            report_mismatch("o_irq", |(sh_isr & sh_ier), irq);
    endtask

    task automatic check_outputs();
        lanes_num_t exp_lanes;
        exp_lanes = sh_cr[CR_LANES_LSB +: LANES_FIELD_W] + 3'd1;
        checks += 11;
        if (assembler_en !== sh_cr[CR_ASM_EN_BIT])
            report_mismatch("o_assembler_en", sh_cr[CR_ASM_EN_BIT], assembler_en);
        if (lanes_en !== sh_cr[CR_LANES_EN_BIT])
            report_mismatch("o_lanes_en", sh_cr[CR_LANES_EN_BIT], lanes_en);
        if (clk_out_en !== sh_cr[CR_CLK_EN_BIT])
            report_mismatch("o_clk_out_en", sh_cr[CR_CLK_EN_BIT], clk_out_en);
        if (send_cmd !== sh_cr[CR_SEND_CMD_BIT])
            report_mismatch("o_send_cmd", sh_cr[CR_SEND_CMD_BIT], send_cmd);
        if (lanes_number !== exp_lanes)
            report_mismatch("o_lanes_number", exp_lanes, lanes_number);
        if (cmd_packet !== sh_cmd[CMD_LSB +: CMD_W])
            report_mismatch("o_cmd_packet", sh_cmd[CMD_LSB +: CMD_W], cmd_packet);
        if (tlpx_timeout !== sh_tr1[TR1_TLPX_LSB +: TIMEOUT_W])
            report_mismatch("o_tlpx_timeout", sh_tr1[TR1_TLPX_LSB +: TIMEOUT_W], tlpx_timeout);
        if (hs_prepare_timeout !== sh_tr1[TR1_PREP_LSB +: TIMEOUT_W])
            report_mismatch("o_hs_prepare_timeout", sh_tr1[TR1_PREP_LSB +: TIMEOUT_W],
                            hs_prepare_timeout);
        if (hs_exit_timeout !== sh_tr1[TR1_EXIT_LSB +: TIMEOUT_W])
            report_mismatch("o_hs_exit_timeout", sh_tr1[TR1_EXIT_LSB +: TIMEOUT_W],
                            hs_exit_timeout);
        if (hs_go_timeout !== sh_tr2[TR2_GO_LSB +: TIMEOUT_W])
            report_mismatch("o_hs_go_timeout", sh_tr2[TR2_GO_LSB +: TIMEOUT_W], hs_go_timeout);
        if (hs_trail_timeout !== sh_tr2[TR2_TRAIL_LSB +: TIMEOUT_W])
            report_mismatch("o_hs_trail_timeout", sh_tr2[TR2_TRAIL_LSB +: TIMEOUT_W],
                            hs_trail_timeout);
    endtask

    // Every completed transfer against the shadow model
    always @(xfer_done) begin : compare_xfer
        avl_resp_t exp_resp;
        exp_resp = (last_idx < NUM_REGS) ? AVL_RESP_OKAY : AVL_RESP_DECODEERR;
        checks++;
        if (last_stall != STALL_CYCLES)
            report_mismatch("o_avl_waitrequest high cycles", STALL_CYCLES, last_stall);
        checks++;
        if (last_resp !== exp_resp)
            report_mismatch($sformatf("o_avl_response[reg %0d]", last_idx), exp_resp, last_resp);
        if (!last_write) begin
            checks++;
            if (last_rdata !== expected_read(last_idx))
                report_mismatch($sformatf("o_avl_readdata[reg %0d]", last_idx),
                                expected_read(last_idx), last_rdata);
        end
        check_outputs();
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
                 WATCHDOG_CYCLES);
        $display("Checks run: %0d, errors: %0d", checks, errors + 1);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : stimulus
        int       n;
        word_t    data;
        reg_idx_t idx;
        void'($urandom(32'h6d524b8f));
        rst_n           = 1'b0;
        avl_addr        = '0;
        avl_read        = 1'b0;
        avl_write       = 1'b0;
        avl_writedata   = '0;
        underflow_set   = 1'b0;
        lanes_ready_set = 1'b0;
        clk_ready_set   = 1'b0;
        lanes_active    = 1'b0;
        model_reset();
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // Reset values
        checks++;
        if (avl_waitrequest !== 1'b0)
            report_mismatch("o_avl_waitrequest", 0, avl_waitrequest);
        for (int i = 0; i < NUM_REGS; i++) begin
            bus_read(reg_idx_t'(i));
        end
        checks++;
        if (irq !== 1'b0)
            report_mismatch("o_irq", 0, irq);

        // Random control register traffic
        for (int i = 0; i < 16; i++) begin
            case ($urandom % 4)
                0:       idx = IDX_CR;
                1:       idx = IDX_TR1;
                2:       idx = IDX_TR2;
                default: idx = IDX_CMD;
            endcase
            bus_write(idx, $urandom);
            bus_read(idx);
        end

        // Send-command drops when the lanes come up
        data                  = $urandom;
        data[CR_SEND_CMD_BIT] = 1'b1;
        bus_write(IDX_CR, data);
        lanes_active = 1'b1;
        n = 0;
        while (send_cmd === 1'b1 && n < 8) begin
            @(posedge clk);
            #10;
            n++;
        end
        checks++;
        if (send_cmd !== 1'b0) begin
            $display("ERROR at %0t ns: o_send_cmd still high %0d cycles after lanes came up",
                     $time, n);
            errors++;
        end
        sh_cr[CR_SEND_CMD_BIT] = 1'b0;
        sh_isr[IRQ_LANES_UP]   = 1'b1;
        idle(3);
        bus_read(IDX_CR);

        // Status set by every source, then cleared
        bus_write(IDX_ISR, '1);
        pulse_event(IRQ_UNDERFLOW);
        pulse_event(IRQ_LANES_READY);
        pulse_event(IRQ_CLK_READY);
        set_lanes_active(1'b0);
        set_lanes_active(1'b1);
        set_lanes_active(1'b0);
        bus_read(IDX_ISR);
        bus_write(IDX_ISR, $urandom);
        bus_read(IDX_ISR);

        // Set pulse lands in the cycle of the clearing strobe
        pulse_event(IRQ_CLK_READY);
        fork
            bus_write(IDX_ISR, word_t'(1) << IRQ_CLK_READY);
            begin
                @(posedge clk);
                #10;
                clk_ready_set = 1'b1;
                @(posedge clk);
                #10;
                clk_ready_set = 1'b0;
            end
        join
        bus_read(IDX_ISR);

        // Interrupt output follows ISR and IER
        for (int i = 0; i < 8; i++) begin
            bus_write(IDX_IER, $urandom);
            idle(3);
            check_irq();
            pulse_event($urandom % 3);
            idle(3);
            check_irq();
            bus_write(IDX_ISR, $urandom);
            idle(3);
            check_irq();
            bus_read(IDX_ISR);
        end

        // Unmapped indexes
        for (int i = NUM_REGS; i < 16; i++) begin
            bus_read(reg_idx_t'(i));
        end
        for (int i = NUM_REGS; i < 16; i++) begin
            bus_write(reg_idx_t'(i), $urandom);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            bus_read(reg_idx_t'(i));
        end

        idle(2);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/dsi_regs_pkg.sv
rtl/reg_bank_if.sv
rtl/avl_reg_agent.sv
rtl/ctrl_reg_bank.sv
rtl/irq_reg_bank.sv
rtl/dsi_tx_regs.sv
sim/tb_dsi_tx_regs.sv
